/* hw/trap_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trap unit constants: widths, queue depth, system opcodes, CSR map, causes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TRAP_PARAMS_SVH
`define TRAP_PARAMS_SVH

`define XLEN        32           // data and address width
`define FIFO_DEPTH  4            // queue slots, also credits after reset

// full 32-bit system instruction encodings
`define INST_ECALL  32'h00000073
`define INST_EBREAK 32'h00100073
`define INST_MRET   32'h30200073

// machine CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// synchronous exception codes for mcause
`define CAUSE_ECALL  11
`define CAUSE_EBREAK 3

`endif

/* hw/trap_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trap unit shared types: retire bundle, trap request, CSR write, redirect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "trap_params.svh"

package trap_pkg;

    // what the decoder made of a retired instruction
    typedef enum logic [1:0] {
        TK_NONE   = 2'd0,    // ordinary instruction, no action
        TK_ECALL  = 2'd1,
        TK_EBREAK = 2'd2,
        TK_MRET   = 2'd3
    } trap_kind_e;

    // one retired instruction as offered by the pipeline
    typedef struct packed {
        logic [31:0]      inst;       // raw encoding
        logic [`XLEN-1:0] pc;         // address of inst
        logic             jump;       // ex stage took a jump
        logic [`XLEN-1:0] jump_addr;  // target of that jump
    } retire_t;

    // queued request for the sequencer
    typedef struct packed {
        trap_kind_e       kind;
        logic [`XLEN-1:0] epc;        // return address to save in mepc
    } trap_req_t;

    // single CSR write beat
    typedef struct packed {
        logic             we;
        logic [11:0]      addr;       // CSR address space is 12 bits
        logic [`XLEN-1:0] data;
    } csr_wr_t;

    // fetch redirect, valid for one cycle
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

/* hw/sys_inst_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system instruction decoder, turns each retire into a registered trap request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trap_params.svh"

module sys_inst_decode (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  ret_valid_i,   // one retire per cycle at most
    input  trap_pkg::retire_t     ret_i,
    output logic                  req_valid_o,   // push strobe for the queue
    output trap_pkg::trap_req_t   req_o
);

    trap_pkg::trap_kind_e kind_d;
    logic [`XLEN-1:0]     epc_d;

    // exact match on the full word, funct/rs/rd fields all zero
    always_comb begin
        if (ret_i.inst == `INST_ECALL) begin
            kind_d = trap_pkg::TK_ECALL;
        end else if (ret_i.inst == `INST_EBREAK) begin
            kind_d = trap_pkg::TK_EBREAK;
        end else if (ret_i.inst == `INST_MRET) begin
            kind_d = trap_pkg::TK_MRET;
        end else begin
            kind_d = trap_pkg::TK_NONE;  // still queued, keeps credits balanced
        end
    end

    // a jump already in flight means the trap returns to its target
    assign epc_d = ret_i.jump ? (ret_i.jump_addr - `XLEN'd4) : ret_i.pc;

    // strobe is control, cleared by reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= ret_valid_i;
        end
    end

    // payload only loads on a real retire
    always_ff @(posedge clk) begin
        if (ret_valid_i) begin
            req_o.kind <= kind_d;
            req_o.epc  <= epc_d;
        end
    end

endmodule

/* hw/credit_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// show-ahead queue, one credit pulse back upstream per popped entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trap_params.svh"

module credit_fifo #(
    parameter type T_PAYLOAD = logic [7:0],
    parameter int  DEPTH     = `FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     push_i,        // sender honours credits, never full here
    input  T_PAYLOAD push_data_i,
    input  logic     pop_i,
    output T_PAYLOAD pop_data_o,    // head entry, valid while not empty
    output logic     empty_o,
    output logic     crd_ret_o      // one-cycle pulse per pop
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T_PAYLOAD        mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    assign do_push = push_i;
    assign do_pop  = pop_i & ~empty_o;  // ignore a pop on an empty queue

    assign empty_o    = (count == '0);
    assign pop_data_o = mem[rd_ptr];    // show-ahead read

    // storage has no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            crd_ret_o <= 1'b0;
        end else begin
            if (do_push) begin
                // wrap by compare, DEPTH need not be a power of two
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
            crd_ret_o <= do_pop;  // credit goes back the cycle after the pop
        end
    end

endmodule

/* hw/clint.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine trap sequencer: CSR save on ecall/ebreak, restore on mret, redirect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trap_params.svh"

module clint (
    input  logic                  clk,
    input  logic                  arst_n_i,
    // from the queue
    input  trap_pkg::trap_req_t   req_i,       // head entry
    input  logic                  empty_i,
    output logic                  pop_o,
    // from csr_regs
    input  logic [`XLEN-1:0]      mstatus_i,
    input  logic [`XLEN-1:0]      mtvec_i,
    input  logic [`XLEN-1:0]      mepc_i,
    // to csr_regs
    output trap_pkg::csr_wr_t     csr_wr_o,
    // to pipeline
    output logic                  hold_o,
    output trap_pkg::redirect_t   redirect_o
);

    // one-hot state encoding
    localparam logic [4:0] S_IDLE    = 5'b00001;
    localparam logic [4:0] S_MEPC    = 5'b00010;  // mepc write on the wire
    localparam logic [4:0] S_MSTATUS = 5'b00100;  // mstatus save on the wire
    localparam logic [4:0] S_MCAUSE  = 5'b01000;  // mcause write plus redirect
    localparam logic [4:0] S_MRET    = 5'b10000;  // mstatus restore plus redirect

    logic [4:0]          state_q;
    logic [4:0]          state_d;
    logic [`XLEN-1:0]    cause_q;      // held from pop until the mcause beat
    logic                is_trap;
    logic [`XLEN-1:0]    mstatus_trap;
    logic [`XLEN-1:0]    mstatus_ret;
    trap_pkg::csr_wr_t   wr_d;
    trap_pkg::redirect_t redir_d;

    assign hold_o  = (state_q != S_IDLE);
    assign pop_o   = (state_q == S_IDLE) & ~empty_i;  // one entry at a time
    assign is_trap = (req_i.kind == trap_pkg::TK_ECALL) ||
                     (req_i.kind == trap_pkg::TK_EBREAK);

    // trap entry: MPIE <= MIE, MIE <= 0
    assign mstatus_trap = {mstatus_i[`XLEN-1:8], mstatus_i[3], mstatus_i[6:4],
                           1'b0, mstatus_i[2:0]};
    // return: MIE <= MPIE, MPIE <= 1
    assign mstatus_ret  = {mstatus_i[`XLEN-1:8], 1'b1, mstatus_i[6:4],
                           mstatus_i[7], mstatus_i[2:0]};

    // next state and the write beat that goes with it
    // outputs are registered, so each beat is decided one edge ahead
    always_comb begin
        state_d = S_IDLE;
        wr_d    = '0;
        redir_d = '0;
        case (state_q)
            S_IDLE: begin
                if (pop_o && is_trap) begin
                    state_d    = S_MEPC;
                    wr_d.we    = 1'b1;
                    wr_d.addr  = `CSR_MEPC;
                    wr_d.data  = req_i.epc;  // straight from the head entry
                end else if (pop_o && (req_i.kind == trap_pkg::TK_MRET)) begin
                    state_d        = S_MRET;
                    wr_d.we        = 1'b1;
                    wr_d.addr      = `CSR_MSTATUS;
                    wr_d.data      = mstatus_ret;
                    redir_d.valid  = 1'b1;
                    redir_d.target = mepc_i;
                end
                // TK_NONE pops and stays idle
            end
            S_MEPC: begin
                state_d   = S_MSTATUS;
                wr_d.we   = 1'b1;
                wr_d.addr = `CSR_MSTATUS;
                wr_d.data = mstatus_trap;
            end
            S_MSTATUS: begin
                state_d        = S_MCAUSE;
                wr_d.we        = 1'b1;
                wr_d.addr      = `CSR_MCAUSE;
                wr_d.data      = cause_q;
                redir_d.valid  = 1'b1;
                redir_d.target = mtvec_i;  // direct mode only
            end
            default: begin
                state_d = S_IDLE;  // MCAUSE and MRET finish here
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= S_IDLE;
            csr_wr_o   <= '0;
            redirect_o <= '0;
        end else begin
            state_q    <= state_d;
            csr_wr_o   <= wr_d;
            redirect_o <= redir_d;
        end
    end

    // cause code captured with the pop
    always_ff @(posedge clk) begin
        if (pop_o && is_trap) begin
            cause_q <= (req_i.kind == trap_pkg::TK_ECALL) ? `XLEN'(`CAUSE_ECALL)
                                                          : `XLEN'(`CAUSE_EBREAK);
        end
    end

endmodule

/* hw/csr_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine CSR file: mstatus, mtvec, mepc, mcause with hw and sw write ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trap_params.svh"

module csr_regs (
    input  logic                clk,
    input  logic                arst_n_i,
    input  trap_pkg::csr_wr_t   hw_wr_i,      // from the sequencer, wins
    input  trap_pkg::csr_wr_t   sw_wr_i,      // software port
    input  logic [11:0]         raddr_i,
    output logic [`XLEN-1:0]    rdata_o,
    output logic [`XLEN-1:0]    mstatus_o,
    output logic [`XLEN-1:0]    mtvec_o,
    output logic [`XLEN-1:0]    mepc_o
);

    logic [`XLEN-1:0]  mstatus_q;
    logic [`XLEN-1:0]  mtvec_q;
    logic [`XLEN-1:0]  mepc_q;
    logic [`XLEN-1:0]  mcause_q;
    trap_pkg::csr_wr_t wr;             // the write that lands this cycle

    // sequencer beat beats software, colliding sw write is lost
    assign wr = hw_wr_i.we ? hw_wr_i : sw_wr_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (wr.we) begin
            case (wr.addr)
                `CSR_MSTATUS: mstatus_q <= wr.data;
                `CSR_MTVEC:   mtvec_q   <= wr.data;
                `CSR_MEPC:    mepc_q    <= wr.data;
                `CSR_MCAUSE:  mcause_q  <= wr.data;
                default:      ;  // unmapped address, dropped
            endcase
        end
    end

    // software read, combinational
    always_comb begin
        case (raddr_i)
            `CSR_MSTATUS: rdata_o = mstatus_q;
            `CSR_MTVEC:   rdata_o = mtvec_q;
            `CSR_MEPC:    rdata_o = mepc_q;
            `CSR_MCAUSE:  rdata_o = mcause_q;
            default:      rdata_o = '0;  // unknown reads as zero
        endcase
    end

    // direct taps for the sequencer
    assign mstatus_o = mstatus_q;
    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;

endmodule

/* hw/trap_unit_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trap unit top: decoder, credit queue, sequencer and CSR file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trap_params.svh"

module trap_unit_top (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  ret_valid_i,   // only sent while holding a credit
    input  trap_pkg::retire_t     ret_i,
    output logic                  crd_ret_o,
    output logic                  hold_o,
    output trap_pkg::redirect_t   redirect_o,
    input  trap_pkg::csr_wr_t     csr_sw_i,
    input  logic [11:0]           csr_raddr_i,
    output logic [`XLEN-1:0]      csr_rdata_o
);

    logic                req_valid;
    trap_pkg::trap_req_t req;
    trap_pkg::trap_req_t head;       // queue head, show-ahead
    logic                empty;
    logic                pop;
    trap_pkg::csr_wr_t   hw_wr;
    logic [`XLEN-1:0]    mstatus;
    logic [`XLEN-1:0]    mtvec;
    logic [`XLEN-1:0]    mepc;

    sys_inst_decode u_decode (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .ret_valid_i (ret_valid_i),
        .ret_i       (ret_i),
        .req_valid_o (req_valid),
        .req_o       (req)
    );

    credit_fifo #(
        .T_PAYLOAD (trap_pkg::trap_req_t),
        .DEPTH     (`FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .push_i      (req_valid),
        .push_data_i (req),
        .pop_i       (pop),
        .pop_data_o  (head),
        .empty_o     (empty),
        .crd_ret_o   (crd_ret_o)
    );

    clint u_clint (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (head),
        .empty_i    (empty),
        .pop_o      (pop),
        .mstatus_i  (mstatus),
        .mtvec_i    (mtvec),
        .mepc_i     (mepc),
        .csr_wr_o   (hw_wr),
        .hold_o     (hold_o),
        .redirect_o (redirect_o)
    );

    csr_regs u_csr (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .hw_wr_i   (hw_wr),
        .sw_wr_i   (csr_sw_i),
        .raddr_i   (csr_raddr_i),
        .rdata_o   (csr_rdata_o),
        .mstatus_o (mstatus),
        .mtvec_o   (mtvec),
        .mepc_o    (mepc)
    );

endmodule

/* dv/trap_unit_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trap unit checker: redirect pulse width, hold around CSR writes, reset credits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module trap_unit_chk (
    input logic                clk,
    input logic                arst_n_i,
    input logic                crd_ret_i,
    input logic                hold_i,
    input trap_pkg::redirect_t redirect_i,
    input trap_pkg::csr_wr_t   hw_wr_i      // sequencer write beat
);

    int err_cnt = 0;  // polled by the testbench monitor

    // redirect lasts exactly one cycle
    a_redirect_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect_i.valid |=> !redirect_i.valid)
        else begin
            $error("redirect valid high for two cycles in a row");
            err_cnt++;
        end

    // every sequencer CSR beat happens while the pipeline is held
    a_hold_on_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        hw_wr_i.we |-> hold_i)
        else begin
            $error("CSR write seen while hold is low");
            err_cnt++;
        end

    a_no_credit_in_reset: assert property (@(posedge clk) !arst_n_i |-> !crd_ret_i)
        else begin
            $error("credit returned during reset");
            err_cnt++;
        end

endmodule

bind trap_unit_top trap_unit_chk i_chk (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .crd_ret_i  (crd_ret_o),
    .hold_i     (hold_o),
    .redirect_i (redirect_o),
    .hw_wr_i    (hw_wr)
);

/* dv/tb_trap_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trap unit testbench driving a table of retires under credit flow control
// and reading back the machine CSRs after each one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trap_params.svh"

module tb_trap_unit;

    localparam int TIMEOUT = 200;  // cycles per wait

    typedef struct {
        string       name;
        logic [31:0] inst;
        logic [31:0] pc;
        logic        jump;
        logic [31:0] jump_addr;
        logic        wr_mstatus;   // preload mstatus before sending
        logic [31:0] pre_mstatus;
        logic        exp_redir;
        logic [31:0] exp_target;
        logic [31:0] exp_mcause;
        logic [31:0] exp_mepc;
        logic        exp_mie;
        logic        exp_mpie;
    } row_t;

    logic                clk = 1'b0;
    logic                arst_n_i;
    logic                ret_valid_i;
    trap_pkg::retire_t   ret_i;
    logic                crd_ret_o;
    logic                hold_o;
    trap_pkg::redirect_t redirect_o;
    trap_pkg::csr_wr_t   csr_sw_i;
    logic [11:0]         csr_raddr_i;
    logic [`XLEN-1:0]    csr_rdata_o;

    row_t        rows[$];
    logic [63:0] redir_q[$];  // {target, mepc read at that cycle}
    int          sent = 0;
    int          returned = 0;
    int          seed = 88090;
    logic [31:0] mtvec_val;

    trap_unit_top i_dut (.*);

    always #20 clk = ~clk;

    function automatic int credits();
        return `FIFO_DEPTH - sent + returned;  // upstream view
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed) & 32'hFFFF_FFFC;  // word aligned
    endfunction

    function automatic row_t make_row(input string name, input logic [31:0] inst, pc,
                                      input logic jump, input logic [31:0] jaddr,
                                      input logic wr_ms, input logic [31:0] pre_ms,
                                      input logic redir, input logic [31:0] target,
                                      mcause, mepc, input logic mie, mpie);
        return '{name, inst, pc, jump, jaddr, wr_ms, pre_ms, redir, target, mcause,
                 mepc, mie, mpie};
    endfunction

    task automatic stop_failed();
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, act);
        assert (act === exp) else begin
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            ret_valid_i <= 1'b0;
        end
    endtask

    task automatic send_retire(input logic [31:0] inst, pc, input logic jump,
                               input logic [31:0] jaddr);
        int cyc;
        cyc = 0;
        @(posedge clk);
        while (credits() == 0 && cyc < TIMEOUT) begin
            ret_valid_i <= 1'b0;
            @(posedge clk);
            cyc++;
        end
        assert (credits() > 0) else begin
            $display("no credit came back, the instruction could not be sent");
            stop_failed();
        end
        ret_valid_i <= 1'b1;
        ret_i       <= '{inst: inst, pc: pc, jump: jump, jump_addr: jaddr};
        csr_raddr_i <= `CSR_MEPC;  // monitor grabs mepc with each redirect
        sent++;
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        csr_sw_i <= '{we: 1'b1, addr: addr, data: data};
        @(posedge clk);
        csr_sw_i <= '0;
    endtask

    task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        csr_raddr_i <= addr;
        @(negedge clk);
        data = csr_rdata_o;  // comb read settles by mid cycle
    endtask

    task automatic take_redirect(input string name, input logic [31:0] target, mepc);
        int          cyc;
        logic [63:0] seen;
        cyc = 0;
        while (redir_q.size() == 0 && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        assert (redir_q.size() != 0) else begin
            $display("%s: the redirect never came", name);
            stop_failed();
        end
        seen = redir_q.pop_front();
        check_value({name, " target"}, target, seen[63:32]);
        check_value({name, " mepc at redirect"}, mepc, seen[31:0]);
    endtask

    // all credits home and sequencer back in idle
    task automatic wait_settled(input string name);
        int cyc;
        cyc = 0;
        while ((credits() != `FIFO_DEPTH || hold_o) && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        assert (credits() == `FIFO_DEPTH) else begin
            $display("%s: a credit never came back", name);
            stop_failed();
        end
        assert (!hold_o) else begin
            $display("%s: hold never dropped", name);
            stop_failed();
        end
    endtask

    task automatic check_csrs(input string name, input logic [31:0] mcause, mepc,
                              input logic mie, mpie);
        logic [31:0] v;
        read_csr(`CSR_MCAUSE, v);
        check_value({name, " mcause"}, mcause, v);
        read_csr(`CSR_MEPC, v);
        check_value({name, " mepc"}, mepc, v);
        read_csr(`CSR_MTVEC, v);
        check_value({name, " mtvec"}, mtvec_val, v);
        read_csr(`CSR_MSTATUS, v);
        check_value({name, " mstatus.mie"}, mie, v[3]);
        check_value({name, " mstatus.mpie"}, mpie, v[7]);
    endtask

    // credit count and redirect capture sampled mid cycle
    always @(negedge clk) begin
        if (arst_n_i) begin
            if (crd_ret_o) begin
                returned++;
            end
            if (redirect_o.valid) begin
                redir_q.push_back({redirect_o.target, csr_rdata_o});
            end
            assert (credits() >= 0 && credits() <= `FIFO_DEPTH) else begin
                $display("credit count left its range: %0d", credits());
                stop_failed();
            end
            assert (i_dut.i_chk.err_cnt == 0) else begin
                $display("a bound protocol assertion failed");
                stop_failed();
            end
        end
    end

    initial begin
        row_t        r;
        logic [31:0] pc1, pc2, ja2, pc3, pc4, pc5, pa, pb, jb, pc, pd;
        arst_n_i    = 1'b0;
        ret_valid_i = 1'b0;
        ret_i       = '0;
        csr_sw_i    = '0;
        csr_raddr_i = `CSR_MEPC;
        mtvec_val   = rand_word();
        pc1 = rand_word();
        pc2 = rand_word();
        ja2 = rand_word();
        pc3 = rand_word();
        pc4 = rand_word();
        pc5 = rand_word();
        // name, inst, pc, jump, jaddr, preload, mstatus, redir, target, cause, mepc, mie, mpie
        rows.push_back(make_row("ecall_plain", `INST_ECALL, pc1, 1'b0, 32'h0, 1'b1, 32'h0,
                                1'b1, mtvec_val, `CAUSE_ECALL, pc1, 1'b0, 1'b0));
        rows.push_back(make_row("ebreak_jump", `INST_EBREAK, pc2, 1'b1, ja2, 1'b0, 32'h0,
                                1'b1, mtvec_val, `CAUSE_EBREAK, ja2 - 32'd4, 1'b0, 1'b0));
        rows.push_back(make_row("ecall_mie_set", `INST_ECALL, pc3, 1'b0, 32'h0, 1'b1, 32'h8,
                                1'b1, mtvec_val, `CAUSE_ECALL, pc3, 1'b0, 1'b1));
        rows.push_back(make_row("mret_back", `INST_MRET, pc4, 1'b0, 32'h0, 1'b0, 32'h0,
                                1'b1, pc3, `CAUSE_ECALL, pc3, 1'b1, 1'b1));
        rows.push_back(make_row("plain_addi", 32'h00100093, pc5, 1'b0, 32'h0, 1'b0, 32'h0,
                                1'b0, 32'h0, `CAUSE_ECALL, pc3, 1'b1, 1'b1));

        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
        write_csr(`CSR_MTVEC, mtvec_val);

        foreach (rows[i]) begin
            r = rows[i];
            if (r.wr_mstatus) begin
                write_csr(`CSR_MSTATUS, r.pre_mstatus);
            end
            idle_cycles($unsigned($random(seed)) % 4);  // random gap
            send_retire(r.inst, r.pc, r.jump, r.jump_addr);
            idle_cycles(1);
            if (r.exp_redir) begin
                take_redirect(r.name, r.exp_target, r.exp_mepc);
            end
            wait_settled(r.name);
            idle_cycles(3);  // window for a stray redirect
            check_value({r.name, " stray redirects"}, 0, redir_q.size());
            check_csrs(r.name, r.exp_mcause, r.exp_mepc, r.exp_mie, r.exp_mpie);
        end

        // four back to back with a trap at the head fill the queue
        pa = rand_word();
        pb = rand_word();
        jb = rand_word();
        pc = rand_word();
        pd = rand_word();
        write_csr(`CSR_MSTATUS, 32'h8);
        send_retire(`INST_ECALL, pa, 1'b0, 32'h0);
        send_retire(`INST_EBREAK, pb, 1'b1, jb);
        send_retire(32'h00100093, pc, 1'b0, 32'h0);
        send_retire(`INST_EBREAK, pd, 1'b0, 32'h0);
        idle_cycles(1);
        take_redirect("burst first", mtvec_val, pa);
        take_redirect("burst second", mtvec_val, jb - 32'd4);
        take_redirect("burst third", mtvec_val, pd);
        wait_settled("burst");
        idle_cycles(3);
        check_value("burst stray redirects", 0, redir_q.size());
        // only the first of the three traps sees MIE set
        check_csrs("burst", `CAUSE_EBREAK, pd, 1'b0, 1'b0);

        if (i_dut.i_chk.err_cnt == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("a bound protocol assertion failed");
            stop_failed();
        end
    end

endmodule

/* all.f */
+incdir+hw
hw/trap_pkg.sv
hw/sys_inst_decode.sv
hw/credit_fifo.sv
hw/clint.sv
hw/csr_regs.sv
hw/trap_unit_top.sv
dv/trap_unit_chk.sv
dv/tb_trap_unit.sv
